// File: Makefile
VERILATOR ?= verilator
TOP       := tb_top
FILELIST  := list.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal --top-module $(TOP)
SIMARGS   := +verilator+error+limit+100
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := TESTBENCH PASSED
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: check

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(SIMARGS) | tee $(LOG)

check: run
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: bench/soc_sva.sv
`timescale 1ns/1ps

module soc_sva (
  input logic                           clock_i,
  input logic                           rst_n_i,
  input logic                           req_i,
  input logic                           we_i,
  input logic [6:0]                     addr_i,
  input logic                           rvalid_i,
  input logic [soc_pkg::GPIO_WIDTH-1:0] gpio_i,
  input logic                           period_zero_i,
  input logic                           duty_zero_i,
  input logic                           pwm_i
);

  // failure tally read back by the testbench at the end
  int unsigned fail_cnt = 0;
  logic        gpio_write;

  assign gpio_write = req_i && we_i && (addr_i == soc_pkg::ADDR_GPIO_OUT);

  // every request answered one cycle later
  req_answered: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    req_i |=> rvalid_i)
    else begin
      fail_cnt++;
      $error("rvalid did not follow req by one cycle");
    end

  // gpio output moves only right after a gpio write
  gpio_only_on_write: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    !$stable(gpio_i) |-> $past(gpio_write))
    else begin
      fail_cnt++;
      $error("gpio output changed without a gpio write");
    end

  // zero period or duty keeps the pin low
  pwm_low_when_zero: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    (period_zero_i || duty_zero_i) |-> !pwm_i)
    else begin
      fail_cnt++;
      $error("pwm high with zero period or duty");
    end

endmodule

bind periph_regs soc_sva u_soc_sva (
  .clock_i       (clock_i),
  .rst_n_i       (rst_n_i),
  .req_i         (req_i),
  .we_i          (we_i),
  .addr_i        (addr_i),
  .rvalid_i      (rvalid_o),
  .gpio_i        (gpio_o),
  .period_zero_i (~|period_q),
  .duty_zero_i   (~|duty_q),
  .pwm_i         (pwm_o)
);

// File: bench/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  // roughly 12 scans of ~400 cycles, 2 uart frames, pwm window, lots of margin
  localparam int TIMEOUT_CYCLES = 60000;
  localparam int TCK_HALF       = 4;
  localparam int CLKS_PER_BIT   = 8;
  localparam int PWM_PERIOD     = 20;
  localparam int PWM_DUTY       = 5;
  localparam int PWM_WINDOW     = 200;

  // idcode fields: version, part number, manufacturer, fixed one
  localparam logic [31:0] EXP_IDCODE = {4'h0, 16'h5053, 11'h2b7, 1'b1};

  logic                           clock;
  logic                           rst_n;
  logic                           jtag_tck;
  logic                           jtag_tms;
  logic                           jtag_tdi;
  logic                           jtag_trst_n;
  logic                           jtag_tdo;
  logic [soc_pkg::GPIO_WIDTH-1:0] gpio_in;
  logic [soc_pkg::GPIO_WIDTH-1:0] gpio_out;
  logic                           uart_rx;
  logic                           pwm;

  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int seed   = 66;

  soc_top_verilator #(
    .PwmWidth   (16),
    .ClksPerBit (CLKS_PER_BIT)
  ) u_dut (
    .clock_i       (clock),
    .rst_n_i       (rst_n),
    .jtag_tck_i    (jtag_tck),
    .jtag_tms_i    (jtag_tms),
    .jtag_tdi_i    (jtag_tdi),
    .jtag_trst_n_i (jtag_trst_n),
    .jtag_tdo_o    (jtag_tdo),
    .gpio_i        (gpio_in),
    .gpio_o        (gpio_out),
    .uart_rx_i     (uart_rx),
    .pwm_o         (pwm)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    checks++;
    assert (act_v === exp_v) else begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic tck_half(input logic level);
    jtag_tck <= level;
    repeat (TCK_HALF) @(posedge clock);
  endtask

  // one tck period, tdo taken while tck is still low
  task automatic jtag_step(input logic tms_v, input logic tdi_v, output logic tdo_v);
    tdo_v = jtag_tdo;
    jtag_tms <= tms_v;
    jtag_tdi <= tdi_v;
    tck_half(1'b1);
    tck_half(1'b0);
  endtask

  task automatic tap_reset();
    logic tdo_v;
    repeat (5) jtag_step(1'b1, 1'b0, tdo_v);
    jtag_step(1'b0, 1'b0, tdo_v);
  endtask

  // from run-test-idle back to run-test-idle, lsb first
  task automatic ir_scan(input logic [soc_pkg::IR_WIDTH-1:0] ir);
    logic tdo_v;
    int   i;
    jtag_step(1'b1, 1'b0, tdo_v);
    jtag_step(1'b1, 1'b0, tdo_v);
    jtag_step(1'b0, 1'b0, tdo_v);
    jtag_step(1'b0, 1'b0, tdo_v);
    for (i = 0; i < soc_pkg::IR_WIDTH; i++) begin
      jtag_step(i == soc_pkg::IR_WIDTH - 1, ir[i], tdo_v);
    end
    jtag_step(1'b1, 1'b0, tdo_v);
    jtag_step(1'b0, 1'b0, tdo_v);
  endtask

  task automatic dr_scan(input int len, input logic [40:0] din, output logic [40:0] dout);
    logic tdo_v;
    int   i;
    dout = '0;
    // select-dr, capture-dr, then into shift-dr
    jtag_step(1'b1, 1'b0, tdo_v);
    jtag_step(1'b0, 1'b0, tdo_v);
    jtag_step(1'b0, 1'b0, tdo_v);
    for (i = 0; i < len; i++) begin
      jtag_step(i == len - 1, din[i], tdo_v);
      dout[i] = tdo_v;
    end
    // update-dr issues the request, then idle
    jtag_step(1'b1, 1'b0, tdo_v);
    jtag_step(1'b0, 1'b0, tdo_v);
  endtask

  // request scan, idle, nop scan to pull the answer out
  task automatic dmi_access(input logic [6:0] addr, input logic [31:0] data,
                            input logic [1:0] op, output logic [31:0] rdata,
                            output logic [1:0] resp);
    logic [40:0] dout;
    logic        tdo_v;
    dr_scan(soc_pkg::DMI_WIDTH, {addr, data, op}, dout);
    jtag_step(1'b0, 1'b0, tdo_v);
    jtag_step(1'b0, 1'b0, tdo_v);
    dr_scan(soc_pkg::DMI_WIDTH, {7'b0, 32'b0, soc_pkg::DMI_OP_NOP}, dout);
    rdata = dout[33:2];
    resp  = dout[1:0];
  endtask

  task automatic dmi_write(input logic [6:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    logic [31:0] unused_data;
    dmi_access(addr, data, soc_pkg::DMI_OP_WRITE, unused_data, resp);
  endtask

  task automatic dmi_read(input logic [6:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    dmi_access(addr, 32'b0, soc_pkg::DMI_OP_READ, data, resp);
  endtask

  // 8n1 frame, lsb first, one idle bit after stop
  task automatic uart_send(input logic [7:0] b);
    int i;
    uart_rx <= 1'b0;
    repeat (CLKS_PER_BIT) @(posedge clock);
    for (i = 0; i < 8; i++) begin
      uart_rx <= b[i];
      repeat (CLKS_PER_BIT) @(posedge clock);
    end
    uart_rx <= 1'b1;
    repeat (2 * CLKS_PER_BIT) @(posedge clock);
  endtask

  // hang guard
  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout: test sequence still running after %0d cycles", TIMEOUT_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    logic [40:0]                    dout;
    logic [31:0]                    rnd;
    logic [31:0]                    rdata;
    logic [1:0]                     resp;
    logic [soc_pkg::GPIO_WIDTH-1:0] gpio_exp;
    logic [7:0]                     rx_byte;
    logic                           pwm_prev;
    int                             high_cnt;
    int                             sva_fails;
    int                             i;

    rst_n       <= 1'b0;
    jtag_tck    <= 1'b0;
    jtag_tms    <= 1'b1;
    jtag_tdi    <= 1'b0;
    jtag_trst_n <= 1'b1;
    gpio_in     <= '0;
    uart_rx     <= 1'b1;
    repeat (3) @(posedge clock);
    rst_n <= 1'b1;
    repeat (4) @(posedge clock);

    // idcode comes out of the reset instruction
    tap_reset();
    dr_scan(32, '0, dout);
    check_value("idcode", EXP_IDCODE, dout[31:0]);
    ir_scan(soc_pkg::IR_DMI);

    // gpio output writes
    for (i = 0; i < 3; i++) begin
      rnd      = $random(seed);
      gpio_exp = rnd[soc_pkg::GPIO_WIDTH-1:0];
      dmi_write(soc_pkg::ADDR_GPIO_OUT, 32'(gpio_exp), resp);
      check_value("gpio write resp", 32'(soc_pkg::DMI_RESP_OK), 32'(resp));
      check_value("gpio write pin", 32'(gpio_exp), 32'(gpio_out));
    end

    // gpio input readback, zero extended
    rnd = $random(seed);
    gpio_in <= rnd[soc_pkg::GPIO_WIDTH-1:0];
    dmi_read(soc_pkg::ADDR_GPIO_IN, rdata, resp);
    check_value("gpio read data", {12'b0, rnd[soc_pkg::GPIO_WIDTH-1:0]}, rdata);
    check_value("gpio read resp", 32'(soc_pkg::DMI_RESP_OK), 32'(resp));

    // pwm, count high cycles over whole periods after a wrap
    dmi_write(soc_pkg::ADDR_PWM_PERIOD, 32'(PWM_PERIOD), resp);
    dmi_write(soc_pkg::ADDR_PWM_DUTY, 32'(PWM_DUTY), resp);
    pwm_prev = 1'b1;
    @(posedge clock);
    while (!(!pwm_prev && pwm)) begin
      pwm_prev = pwm;
      @(posedge clock);
    end
    high_cnt = 0;
    for (i = 0; i < PWM_WINDOW; i++) begin
      if (pwm) begin
        high_cnt++;
      end
      @(posedge clock);
    end
    check_value("pwm high cycles", 32'((PWM_WINDOW / PWM_PERIOD) * PWM_DUTY),
                32'(high_cnt));

    // uart byte with valid flag, flag cleared by the read
    rnd     = $random(seed);
    rx_byte = rnd[7:0];
    uart_send(rx_byte);
    dmi_read(soc_pkg::ADDR_UART_DATA, rdata, resp);
    check_value("uart first read", {23'b0, 1'b1, rx_byte}, rdata);
    dmi_read(soc_pkg::ADDR_UART_DATA, rdata, resp);
    check_value("uart valid cleared", 32'b0, 32'(rdata[8]));

    // second frame, flag set again
    rnd     = $random(seed);
    rx_byte = rnd[7:0];
    uart_send(rx_byte);
    dmi_read(soc_pkg::ADDR_UART_DATA, rdata, resp);
    check_value("uart second byte", {23'b0, 1'b1, rx_byte}, rdata);

    // unmapped address
    dmi_read(7'd9, rdata, resp);
    check_value("unknown read resp", 32'(soc_pkg::DMI_RESP_ERR), 32'(resp));
    rnd = $random(seed);
    dmi_write(7'd9, rnd, resp);
    check_value("unknown write resp", 32'(soc_pkg::DMI_RESP_ERR), 32'(resp));
    check_value("unknown write gpio", 32'(gpio_exp), 32'(gpio_out));

    sva_fails = int'(u_dut.u_periph.u_soc_sva.fail_cnt);
    $display("checks: %0d, check errors: %0d, assertion failures: %0d",
             checks, errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: design/jtag_tap.sv
`timescale 1ns/1ps

module jtag_tap #(
  parameter logic [31:0] JtagId = 32'h0000_0001
) (
  input  logic        clock_i,
  input  logic        rst_n_i,
  input  logic        tck_i,
  input  logic        tms_i,
  input  logic        tdi_i,
  input  logic        trst_n_i,
  output logic        tdo_o,
  output logic        req_o,
  output logic        we_o,
  output logic [6:0]  addr_o,
  output logic [31:0] wdata_o,
  input  logic        rvalid_i,
  input  logic [31:0] rdata_i,
  input  logic [1:0]  resp_i
);

  // tap states in the usual 1149.1 encoding
  localparam logic [3:0] TEST_LOGIC_RESET = 4'hf;
  localparam logic [3:0] RUN_TEST_IDLE    = 4'hc;
  localparam logic [3:0] SELECT_DR        = 4'h7;
  localparam logic [3:0] CAPTURE_DR       = 4'h6;
  localparam logic [3:0] SHIFT_DR         = 4'h2;
  localparam logic [3:0] EXIT1_DR         = 4'h1;
  localparam logic [3:0] PAUSE_DR         = 4'h3;
  localparam logic [3:0] EXIT2_DR         = 4'h0;
  localparam logic [3:0] UPDATE_DR        = 4'h5;
  localparam logic [3:0] SELECT_IR        = 4'h4;
  localparam logic [3:0] CAPTURE_IR       = 4'he;
  localparam logic [3:0] SHIFT_IR         = 4'ha;
  localparam logic [3:0] EXIT1_IR         = 4'h9;
  localparam logic [3:0] PAUSE_IR         = 4'hb;
  localparam logic [3:0] EXIT2_IR         = 4'h8;
  localparam logic [3:0] UPDATE_IR        = 4'hd;

  logic [3:0]                   pins_q1;
  logic [3:0]                   pins_q2;
  logic                         tck_q3;
  logic                         tck_rise;
  logic                         tck_fall;
  logic                         tms_s;
  logic                         tdi_s;
  logic                         trst_n_s;
  logic [3:0]                   state_q;
  logic [3:0]                   state_d;
  logic [soc_pkg::IR_WIDTH-1:0] ir_q;
  logic [soc_pkg::IR_WIDTH-1:0] ir_shift_q;
  soc_pkg::dmi_word_u           dr_q;
  soc_pkg::dmi_word_u           rsp_word;
  logic [31:0]                  rsp_data_q;
  logic [1:0]                   rsp_resp_q;
  logic                         dmi_go;

  // two-flop sync of all jtag pins, extra tck stage for edges
  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pins_q1 <= '0;
      pins_q2 <= '0;
      tck_q3  <= 1'b0;
    end else begin
      pins_q1 <= {trst_n_i, tdi_i, tms_i, tck_i};
      pins_q2 <= pins_q1;
      tck_q3  <= pins_q2[0];
    end
  end

  assign tck_rise = pins_q2[0] & ~tck_q3;
  assign tck_fall = ~pins_q2[0] & tck_q3;
  assign tms_s    = pins_q2[1];
  assign tdi_s    = pins_q2[2];
  assign trst_n_s = pins_q2[3];

  // tap next state from tms
  always_comb begin
    case (state_q)
      TEST_LOGIC_RESET: state_d = tms_s ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
      RUN_TEST_IDLE:    state_d = tms_s ? SELECT_DR : RUN_TEST_IDLE;
      SELECT_DR:        state_d = tms_s ? SELECT_IR : CAPTURE_DR;
      CAPTURE_DR:       state_d = tms_s ? EXIT1_DR : SHIFT_DR;
      SHIFT_DR:         state_d = tms_s ? EXIT1_DR : SHIFT_DR;
      EXIT1_DR:         state_d = tms_s ? UPDATE_DR : PAUSE_DR;
      PAUSE_DR:         state_d = tms_s ? EXIT2_DR : PAUSE_DR;
      EXIT2_DR:         state_d = tms_s ? UPDATE_DR : SHIFT_DR;
      UPDATE_DR:        state_d = tms_s ? SELECT_DR : RUN_TEST_IDLE;
      SELECT_IR:        state_d = tms_s ? TEST_LOGIC_RESET : CAPTURE_IR;
      CAPTURE_IR:       state_d = tms_s ? EXIT1_IR : SHIFT_IR;
      SHIFT_IR:         state_d = tms_s ? EXIT1_IR : SHIFT_IR;
      EXIT1_IR:         state_d = tms_s ? UPDATE_IR : PAUSE_IR;
      PAUSE_IR:         state_d = tms_s ? EXIT2_IR : PAUSE_IR;
      EXIT2_IR:         state_d = tms_s ? UPDATE_IR : SHIFT_IR;
      default:          state_d = tms_s ? SELECT_DR : RUN_TEST_IDLE;
    endcase
  end

  // response view built from the holding register
  always_comb begin
    rsp_word.rsp.unused = '0;
    rsp_word.rsp.data   = rsp_data_q;
    rsp_word.rsp.resp   = rsp_resp_q;
  end

  // bus request only for read or write ops entering update-dr
  assign dmi_go = tck_rise && (state_d == UPDATE_DR) && (ir_q == soc_pkg::IR_DMI) &&
                  ((dr_q.req.op == soc_pkg::DMI_OP_READ) ||
                   (dr_q.req.op == soc_pkg::DMI_OP_WRITE));

  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= TEST_LOGIC_RESET;
      ir_q       <= soc_pkg::IR_IDCODE;
      ir_shift_q <= '0;
      dr_q       <= '0;
      tdo_o      <= 1'b0;
    end else if (!trst_n_s) begin
      state_q <= TEST_LOGIC_RESET;
      ir_q    <= soc_pkg::IR_IDCODE;
      tdo_o   <= 1'b0;
    end else begin
      if (state_q == TEST_LOGIC_RESET) begin
        ir_q <= soc_pkg::IR_IDCODE;
      end
      if (tck_rise) begin
        state_q <= state_d;
        case (state_q)
          CAPTURE_IR: ir_shift_q <= 5'b00001;
          SHIFT_IR:   ir_shift_q <= {tdi_s, ir_shift_q[soc_pkg::IR_WIDTH-1:1]};
          CAPTURE_DR: begin
            // capture source picked by the instruction
            case (ir_q)
              soc_pkg::IR_IDCODE: dr_q <= {9'b0, JtagId};
              soc_pkg::IR_DMI:    dr_q <= rsp_word;
              default:            dr_q <= '0;
            endcase
          end
          SHIFT_DR: begin
            // shift length follows the selected register
            case (ir_q)
              soc_pkg::IR_DMI:    dr_q <= {tdi_s, dr_q[soc_pkg::DMI_WIDTH-1:1]};
              soc_pkg::IR_IDCODE: dr_q <= {9'b0, tdi_s, dr_q[31:1]};
              default:            dr_q <= {40'b0, tdi_s};
            endcase
          end
          default: ;
        endcase
        if (state_d == UPDATE_IR) begin
          ir_q <= ir_shift_q;
        end
      end
      // tdo moves on the falling edge only
      if (tck_fall) begin
        if (state_q == SHIFT_DR) begin
          tdo_o <= dr_q[0];
        end else if (state_q == SHIFT_IR) begin
          tdo_o <= ir_shift_q[0];
        end else begin
          tdo_o <= 1'b0;
        end
      end
    end
  end

  // request strobe, payload held until the next update
  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_o <= 1'b0;
    end else begin
      req_o <= dmi_go;
    end
  end

  always_ff @(posedge clock_i) begin
    if (dmi_go) begin
      we_o    <= (dr_q.req.op == soc_pkg::DMI_OP_WRITE);
      addr_o  <= dr_q.req.addr;
      wdata_o <= dr_q.req.data;
    end
  end

  // last answer kept for the next dmi capture
  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_data_q <= '0;
      rsp_resp_q <= soc_pkg::DMI_RESP_OK;
    end else if (rvalid_i) begin
      rsp_data_q <= rdata_i;
      rsp_resp_q <= resp_i;
    end
  end

endmodule

// File: design/periph_regs.sv
`timescale 1ns/1ps

module periph_regs #(
  parameter int PwmWidth   = 16,
  parameter int ClksPerBit = 8
) (
  input  logic                           clock_i,
  input  logic                           rst_n_i,
  input  logic                           req_i,
  input  logic                           we_i,
  input  logic [6:0]                     addr_i,
  input  logic [31:0]                    wdata_i,
  output logic                           rvalid_o,
  output logic [31:0]                    rdata_o,
  output logic [1:0]                     resp_o,
  input  logic [soc_pkg::GPIO_WIDTH-1:0] gpio_i,
  output logic [soc_pkg::GPIO_WIDTH-1:0] gpio_o,
  input  logic                           uart_rx_i,
  output logic                           pwm_o
);

  logic [soc_pkg::GPIO_WIDTH-1:0] gpio_in_q1;
  logic [soc_pkg::GPIO_WIDTH-1:0] gpio_in_q2;
  logic [PwmWidth-1:0]            period_q;
  logic [PwmWidth-1:0]            duty_q;
  logic                           uart_done;
  logic [7:0]                     uart_data;
  logic                           uart_valid_q;
  logic                           addr_known;
  logic                           uart_read;
  logic [31:0]                    rdata_d;

  // map ends at the uart data register
  assign addr_known = (addr_i <= soc_pkg::ADDR_UART_DATA);
  assign uart_read  = req_i && !we_i && (addr_i == soc_pkg::ADDR_UART_DATA);

  // gpio inputs come from outside, sync them
  always_ff @(posedge clock_i) begin
    gpio_in_q1 <= gpio_i;
    gpio_in_q2 <= gpio_in_q1;
  end

  // read mux
  always_comb begin
    case (addr_i)
      soc_pkg::ADDR_GPIO_OUT:   rdata_d = 32'(gpio_o);
      soc_pkg::ADDR_GPIO_IN:    rdata_d = 32'(gpio_in_q2);
      soc_pkg::ADDR_PWM_PERIOD: rdata_d = 32'(period_q);
      soc_pkg::ADDR_PWM_DUTY:   rdata_d = 32'(duty_q);
      soc_pkg::ADDR_UART_DATA:  rdata_d = {23'b0, uart_valid_q, uart_data};
      default:                  rdata_d = '0;
    endcase
  end

  // writable registers, read-only addresses ignore writes
  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_o   <= '0;
      period_q <= '0;
      duty_q   <= '0;
    end else if (req_i && we_i) begin
      case (addr_i)
        soc_pkg::ADDR_GPIO_OUT:   gpio_o   <= wdata_i[soc_pkg::GPIO_WIDTH-1:0];
        soc_pkg::ADDR_PWM_PERIOD: period_q <= wdata_i[PwmWidth-1:0];
        soc_pkg::ADDR_PWM_DUTY:   duty_q   <= wdata_i[PwmWidth-1:0];
        default: ;
      endcase
    end
  end

  // answer one cycle after the request
  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

  always_ff @(posedge clock_i) begin
    if (req_i) begin
      rdata_o <= we_i ? 32'b0 : rdata_d;
      resp_o  <= addr_known ? soc_pkg::DMI_RESP_OK : soc_pkg::DMI_RESP_ERR;
    end
  end

  // uart valid flag, a new byte wins over a clearing read
  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      uart_valid_q <= 1'b0;
    end else if (uart_done) begin
      uart_valid_q <= 1'b1;
    end else if (uart_read) begin
      uart_valid_q <= 1'b0;
    end
  end

  pwm_gen #(
    .PwmWidth (PwmWidth)
  ) u_pwm (
    .clock_i  (clock_i),
    .rst_n_i  (rst_n_i),
    .period_i (period_q),
    .duty_i   (duty_q),
    .pwm_o    (pwm_o)
  );

  uart_rx #(
    .ClksPerBit (ClksPerBit)
  ) u_uart_rx (
    .clock_i (clock_i),
    .rst_n_i (rst_n_i),
    .rx_i    (uart_rx_i),
    .done_o  (uart_done),
    .data_o  (uart_data)
  );

endmodule

// File: design/pwm_gen.sv
`timescale 1ns/1ps

module pwm_gen #(
  parameter int PwmWidth = 16
) (
  input  logic                clock_i,
  input  logic                rst_n_i,
  input  logic [PwmWidth-1:0] period_i,
  input  logic [PwmWidth-1:0] duty_i,
  output logic                pwm_o
);

  logic [PwmWidth-1:0] cnt_q;
  logic [PwmWidth-1:0] period_q;
  logic                wrap;

  // zero period wraps every cycle so a new period is picked up at once
  assign wrap = (period_q == '0) || (cnt_q == period_q - 1'b1);

  // period only reloads at the wrap
  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q    <= '0;
      period_q <= '0;
    end else if (wrap) begin
      cnt_q    <= '0;
      period_q <= period_i;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // high below duty, low whenever a period is zero
  assign pwm_o = (period_i != '0) && (period_q != '0) && (cnt_q < duty_i);

endmodule

// File: design/soc_pkg.sv
package soc_pkg;

  // integer widths
  localparam int IR_WIDTH   = 5;
  localparam int DMI_WIDTH  = 41;
  localparam int GPIO_WIDTH = 20;

  // dmi scan word, request view at update, response view at capture
  typedef union packed {
    struct packed {
      logic [6:0]  addr;
      logic [31:0] data;
      logic [1:0]  op;
    } req;
    struct packed {
      logic [6:0]  unused;
      logic [31:0] data;
      logic [1:0]  resp;
    } rsp;
  } dmi_word_u;

  // dmi op codes
  localparam logic [1:0] DMI_OP_NOP   = 2'd0;
  localparam logic [1:0] DMI_OP_READ  = 2'd1;
  localparam logic [1:0] DMI_OP_WRITE = 2'd2;

  // dmi response codes
  localparam logic [1:0] DMI_RESP_OK  = 2'd0;
  localparam logic [1:0] DMI_RESP_ERR = 2'd2;

  // peripheral register map
  localparam logic [6:0] ADDR_GPIO_OUT   = 7'd0;
  localparam logic [6:0] ADDR_GPIO_IN    = 7'd1;
  localparam logic [6:0] ADDR_PWM_PERIOD = 7'd2;
  localparam logic [6:0] ADDR_PWM_DUTY   = 7'd3;
  localparam logic [6:0] ADDR_UART_DATA  = 7'd4;

  // jtag instruction codes
  localparam logic [IR_WIDTH-1:0] IR_IDCODE = 5'd1;
  localparam logic [IR_WIDTH-1:0] IR_DMI    = 5'd17;
  localparam logic [IR_WIDTH-1:0] IR_BYPASS = 5'd31;

endpackage

// File: design/soc_top_verilator.sv
`timescale 1ns/1ps

module soc_top_verilator #(
  parameter int PwmWidth   = 16,
  parameter int ClksPerBit = 8
) (
  input  logic                           clock_i,
  input  logic                           rst_n_i,
  input  logic                           jtag_tck_i,
  input  logic                           jtag_tms_i,
  input  logic                           jtag_tdi_i,
  input  logic                           jtag_trst_n_i,
  output logic                           jtag_tdo_o,
  input  logic [soc_pkg::GPIO_WIDTH-1:0] gpio_i,
  output logic [soc_pkg::GPIO_WIDTH-1:0] gpio_o,
  input  logic                           uart_rx_i,
  output logic                           pwm_o
);

  // idcode fields: version, part number, manufacturer, fixed one
  localparam logic [31:0] JtagIdcode = {
    4'h0,
    16'h5053,
    11'h2b7,
    1'b1
  };

  // debug bus between tap and peripherals
  logic        bus_req;
  logic        bus_we;
  logic [6:0]  bus_addr;
  logic [31:0] bus_wdata;
  logic        bus_rvalid;
  logic [31:0] bus_rdata;
  logic [1:0]  bus_resp;

  jtag_tap #(
    .JtagId (JtagIdcode)
  ) u_tap (
    .clock_i  (clock_i),
    .rst_n_i  (rst_n_i),
    .tck_i    (jtag_tck_i),
    .tms_i    (jtag_tms_i),
    .tdi_i    (jtag_tdi_i),
    .trst_n_i (jtag_trst_n_i),
    .tdo_o    (jtag_tdo_o),
    .req_o    (bus_req),
    .we_o     (bus_we),
    .addr_o   (bus_addr),
    .wdata_o  (bus_wdata),
    .rvalid_i (bus_rvalid),
    .rdata_i  (bus_rdata),
    .resp_i   (bus_resp)
  );

  periph_regs #(
    .PwmWidth   (PwmWidth),
    .ClksPerBit (ClksPerBit)
  ) u_periph (
    .clock_i   (clock_i),
    .rst_n_i   (rst_n_i),
    .req_i     (bus_req),
    .we_i      (bus_we),
    .addr_i    (bus_addr),
    .wdata_i   (bus_wdata),
    .rvalid_o  (bus_rvalid),
    .rdata_o   (bus_rdata),
    .resp_o    (bus_resp),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .uart_rx_i (uart_rx_i),
    .pwm_o     (pwm_o)
  );

endmodule

// File: design/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
  parameter int ClksPerBit = 8
) (
  input  logic       clock_i,
  input  logic       rst_n_i,
  input  logic       rx_i,
  output logic       done_o,
  output logic [7:0] data_o
);

  localparam int CntW = $clog2(ClksPerBit + 1);

  // receiver states
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_START = 2'd1;
  localparam logic [1:0] ST_DATA  = 2'd2;
  localparam logic [1:0] ST_STOP  = 2'd3;

  logic            rx_q1;
  logic            rx_q2;
  logic [1:0]      state_q;
  logic [CntW-1:0] cnt_q;
  logic [2:0]      bit_idx_q;
  logic [7:0]      shift_q;
  logic            bit_end;
  logic            half_bit;

  assign bit_end  = (cnt_q == CntW'(ClksPerBit - 1));
  assign half_bit = (cnt_q == CntW'(ClksPerBit / 2 - 1));

  // line idles high
  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_q1 <= 1'b1;
      rx_q2 <= 1'b1;
    end else begin
      rx_q1 <= rx_i;
      rx_q2 <= rx_q1;
    end
  end

  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= ST_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= 1'b0;
      cnt_q  <= cnt_q + 1'b1;
      case (state_q)
        ST_IDLE: begin
          cnt_q <= '0;
          if (!rx_q2) begin
            state_q <= ST_START;
          end
        end
        // recheck start at half a bit, a glitch goes back to idle
        ST_START: begin
          if (half_bit) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            state_q   <= rx_q2 ? ST_IDLE : ST_DATA;
          end
        end
        // lsb first, sampled mid-bit
        ST_DATA: begin
          if (bit_end) begin
            cnt_q     <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= ST_STOP;
            end
          end
        end
        default: begin
          // bad stop bit drops the frame
          if (bit_end) begin
            state_q <= ST_IDLE;
            done_o  <= rx_q2;
          end
        end
      endcase
    end
  end

  // data path, holding register overwritten by every good frame
  always_ff @(posedge clock_i) begin
    if (state_q == ST_DATA && bit_end) begin
      shift_q <= {rx_q2, shift_q[7:1]};
    end
    if (state_q == ST_STOP && bit_end && rx_q2) begin
      data_o <= shift_q;
    end
  end

endmodule

// File: list.f
design/soc_pkg.sv
design/pwm_gen.sv
design/uart_rx.sv
design/periph_regs.sv
design/jtag_tap.sv
design/soc_top_verilator.sv
bench/soc_sva.sv
bench/tb_top.sv
